// ==== hdl/pix_pkg.sv ====
package pix_pkg;

    // token type carried with every stream word.
    typedef enum logic [3:0] {
        dtype_header      = 4'h0,
        dtype_frame_start = 4'h1,
        dtype_frame_end   = 4'h2,
        dtype_row_start   = 4'h3,
        dtype_row_end     = 4'h4,
        dtype_pixel       = 4'h8
    } dtype_t;

    // what the decode stage reports for each token.
    // header words decode as kind_other.
    typedef enum logic [2:0] {
        kind_other       = 3'd0,
        kind_frame_start = 3'd1,
        kind_frame_end   = 3'd2,
        kind_row_start   = 3'd3,
        kind_row_end     = 3'd4,
        kind_pixel       = 3'd5
    } kind_t;

    // filter sequencing.
    typedef enum logic [1:0] {
        st_pass    = 2'd0, // tokens outside rows go straight through.
        st_row     = 2'd1, // pixels are delayed by one slot.
        st_row_end = 2'd2  // row end goes out after the last pixel.
    } filt_state_t;

    // width of the per-frame defect and row counters.
    localparam int count_width = 16;

endpackage

// ==== hdl/stream_decode.sv ====
`timescale 1ns/10ps

module stream_decode #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  resetb,
    input  logic                  dvi,
    input  logic [DATA_WIDTH-1:0] datai,
    input  pix_pkg::dtype_t       dtypei,
    output logic                  dec_dv,
    output logic [DATA_WIDTH-1:0] dec_data,
    output pix_pkg::kind_t        dec_kind,
    output logic                  frame_error
);

    import pix_pkg::*;

    logic  in_frame;
    logic  in_row;
    kind_t kind;
    logic  violation;

    function automatic kind_t classify(input dtype_t t);
        case (t)
            dtype_frame_start: return kind_frame_start;
            dtype_frame_end:   return kind_frame_end;
            dtype_row_start:   return kind_row_start;
            dtype_row_end:     return kind_row_end;
            dtype_pixel:       return kind_pixel;
            default:           return kind_other;
        endcase
    endfunction

    assign kind = classify(dtypei);

    // framing order checks.
    assign violation = dvi && (((kind == kind_pixel) && !in_row) ||
                               ((kind == kind_row_start) && in_row) ||
                               ((kind == kind_frame_end) && in_row) ||
                               ((kind == kind_frame_start) && in_frame));

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            dec_dv      <= 1'b0;
            dec_kind    <= kind_other;
            in_frame    <= 1'b0;
            in_row      <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            dec_dv <= dvi;
            if (dvi) begin
                dec_kind <= kind;
                case (kind)
                    kind_frame_start: in_frame <= 1'b1;
                    kind_frame_end: begin
                        in_frame <= 1'b0;
                        in_row   <= 1'b0;
                    end
                    kind_row_start:   in_row <= 1'b1;
                    kind_row_end:     in_row <= 1'b0;
                    default: ;
                endcase
            end
            if (violation) frame_error <= 1'b1; // sticky until reset.
        end
    end

    always_ff @(posedge clk) begin
        if (dvi) dec_data <= datai;
    end

    a_legal_dtype: assert property (
        @(posedge clk) disable iff (!resetb)
        dvi |-> dtypei inside {dtype_header, dtype_frame_start, dtype_frame_end,
                               dtype_row_start, dtype_row_end, dtype_pixel}
    ) else $error("illegal token type on input stream.");

endmodule

// ==== hdl/defect_filter.sv ====
`timescale 1ns/10ps

module defect_filter #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                         clk,
    input  logic                         resetb,
    input  logic                         en,
    input  logic signed [DATA_WIDTH-1:0] threshold_upper,
    input  logic signed [DATA_WIDTH-1:0] threshold_lower,
    input  logic                         dec_dv,
    input  logic [DATA_WIDTH-1:0]        dec_data,
    input  pix_pkg::kind_t               dec_kind,
    output logic                         dvo,
    output logic [DATA_WIDTH-1:0]        datao,
    output pix_pkg::dtype_t              dtypeo,
    output logic                         defect
);

    import pix_pkg::*;

    filt_state_t state;
    logic [1:0]  pix_cnt;              // pixels seen in the row, saturates at 2.

    // mid_q holds whatever token is waiting for its slot.
    logic [DATA_WIDTH-1:0] mid_q;
    logic [DATA_WIDTH-1:0] left_q;     // last pixel emitted in this row.

    logic signed [DATA_WIDTH-1:0] d1;
    logic signed [DATA_WIDTH-1:0] d2;
    logic signed [DATA_WIDTH-1:0] neg_lower;
    logic [DATA_WIDTH:0]          sum;
    logic [DATA_WIDTH-1:0]        mean;
    logic [DATA_WIDTH-1:0]        out_pix;
    logic                         hot;
    logic                         cold;
    logic                         check;
    logic                         is_defect;
    logic                         row_tok;

    function automatic dtype_t kind_to_dtype(input kind_t k);
        case (k)
            kind_frame_start: return dtype_frame_start;
            kind_frame_end:   return dtype_frame_end;
            kind_row_start:   return dtype_row_start;
            kind_row_end:     return dtype_row_end;
            kind_pixel:       return dtype_pixel;
            default:          return dtype_header;
        endcase
    endfunction

    assign d1        = mid_q - dec_data; // positive when right is darker.
    assign d2        = mid_q - left_q;   // positive when left is darker.
    assign neg_lower = -threshold_lower;

    assign sum  = {1'b0, left_q} + {1'b0, dec_data};
    assign mean = sum[DATA_WIDTH:1];

    assign hot   = (d1 > threshold_upper) && (d2 > threshold_upper);
    assign cold  = (d1 < neg_lower) && (d2 < neg_lower);
    // only a pixel with both neighbours in the row is checked.
    assign check = (state == st_row) && dec_dv && (dec_kind == kind_pixel) &&
                   (pix_cnt == 2'd2);
    assign is_defect = check && (hot || cold);

    assign out_pix = (is_defect && en) ? mean : mid_q;

    assign row_tok = dec_dv && ((dec_kind == kind_pixel) || (dec_kind == kind_row_end));

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            state   <= st_pass;
            pix_cnt <= 2'd0;
            dvo     <= 1'b0;
            defect  <= 1'b0;
        end else begin
            dvo    <= 1'b0;
            defect <= 1'b0;
            case (state)
                st_pass: begin
                    if (dec_dv && (dec_kind == kind_row_start)) begin
                        state   <= st_row; // row start waits for the first pixel.
                        pix_cnt <= 2'd0;
                    end else begin
                        dvo <= dec_dv;
                    end
                end
                st_row: begin
                    if (dec_dv && (dec_kind == kind_pixel)) begin
                        dvo    <= 1'b1;
                        defect <= is_defect;
                        if (pix_cnt != 2'd2) pix_cnt <= pix_cnt + 2'd1;
                    end else if (dec_dv && (dec_kind == kind_row_end)) begin
                        dvo   <= 1'b1;
                        state <= st_row_end;
                    end
                end
                st_row_end: begin
                    dvo   <= 1'b1;
                    state <= st_pass;
                end
                default: state <= st_pass;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_pass: begin
                if (dec_dv) begin
                    datao  <= dec_data;
                    dtypeo <= kind_to_dtype(dec_kind);
                    mid_q  <= dec_data;
                end
            end
            st_row: begin
                if (row_tok) begin
                    mid_q <= dec_data;
                    if (pix_cnt == 2'd0) begin
                        datao  <= mid_q;  // held row start goes out now.
                        dtypeo <= dtype_row_start;
                    end else begin
                        datao  <= out_pix;
                        dtypeo <= dtype_pixel;
                        left_q <= out_pix;
                    end
                end
            end
            st_row_end: begin
                datao  <= mid_q;
                dtypeo <= dtype_row_end;
            end
            default: ;
        endcase
    end

    // the source must idle for a cycle after every row end.
    a_idle_after_row_end: assert property (
        @(posedge clk) disable iff (!resetb)
        (state == st_row_end) |-> !dec_dv
    ) else $error("token arrived while row end was still pending.");

endmodule

// ==== hdl/frame_stats.sv ====
`timescale 1ns/10ps

module frame_stats (
    input  logic                            clk,
    input  logic                            resetb,
    input  logic                            dvo,
    input  pix_pkg::dtype_t                 dtypeo,
    input  logic                            defect,
    output logic [pix_pkg::count_width-1:0] defect_count,
    output logic [pix_pkg::count_width-1:0] row_count,
    output logic                            stats_valid
);

    import pix_pkg::*;

    logic [count_width-1:0] cur_defects;
    logic [count_width-1:0] cur_rows;
    logic                   in_row;

    logic ev_frame_start;
    logic ev_frame_end;
    logic ev_row_start;
    logic ev_row_end;

    assign ev_frame_start = dvo && (dtypeo == dtype_frame_start);
    assign ev_frame_end   = dvo && (dtypeo == dtype_frame_end);
    assign ev_row_start   = dvo && (dtypeo == dtype_row_start);
    assign ev_row_end     = dvo && (dtypeo == dtype_row_end);

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            cur_defects  <= '0;
            cur_rows     <= '0;
            in_row       <= 1'b0;
            defect_count <= '0;
            row_count    <= '0;
            stats_valid  <= 1'b0;
        end else begin
            stats_valid <= 1'b0;

            if (ev_frame_start) begin
                cur_defects <= '0;
                cur_rows    <= '0;
            end else begin
                if (defect && (cur_defects != '1)) cur_defects <= cur_defects + 1'b1;
                if (ev_row_end && (cur_rows != '1)) cur_rows <= cur_rows + 1'b1;
            end

            if (ev_row_start) begin
                in_row <= 1'b1;
            end else if (ev_row_end) begin
                in_row <= 1'b0;
            end

            // publish the finished frame.
            if (ev_frame_end) begin
                defect_count <= cur_defects;
                row_count    <= cur_rows;
                stats_valid  <= 1'b1;
            end
        end
    end

    // a defect always rides on a pixel after the row start went out.
    a_defect_in_row: assert property (
        @(posedge clk) disable iff (!resetb)
        defect |-> (in_row && dvo && (dtypeo == dtype_pixel))
    ) else $error("defect pulse outside a row.");

endmodule

// ==== hdl/pixel_pipe_top.sv ====
`timescale 1ns/10ps

module pixel_pipe_top #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                            clk,
    input  logic                            resetb,
    input  logic                            dvi,
    input  logic [DATA_WIDTH-1:0]           datai,
    input  pix_pkg::dtype_t                 dtypei,
    input  logic                            en,
    input  logic signed [DATA_WIDTH-1:0]    threshold_upper,
    input  logic signed [DATA_WIDTH-1:0]    threshold_lower,
    output logic                            dvo,
    output logic [DATA_WIDTH-1:0]           datao,
    output pix_pkg::dtype_t                 dtypeo,
    output logic                            defect,
    output logic [pix_pkg::count_width-1:0] defect_count,
    output logic [pix_pkg::count_width-1:0] row_count,
    output logic                            stats_valid,
    output logic                            frame_error
);

    import pix_pkg::*;

    logic                  dec_dv;
    logic [DATA_WIDTH-1:0] dec_data;
    kind_t                 dec_kind;

    stream_decode #(.DATA_WIDTH(DATA_WIDTH)) u_decode (
        .clk         (clk),
        .resetb      (resetb),
        .dvi         (dvi),
        .datai       (datai),
        .dtypei      (dtypei),
        .dec_dv      (dec_dv),
        .dec_data    (dec_data),
        .dec_kind    (dec_kind),
        .frame_error (frame_error)
    );

    defect_filter #(.DATA_WIDTH(DATA_WIDTH)) u_filter (
        .clk             (clk),
        .resetb          (resetb),
        .en              (en),
        .threshold_upper (threshold_upper),
        .threshold_lower (threshold_lower),
        .dec_dv          (dec_dv),
        .dec_data        (dec_data),
        .dec_kind        (dec_kind),
        .dvo             (dvo),
        .datao           (datao),
        .dtypeo          (dtypeo),
        .defect          (defect)
    );

    // counts only what the filter emitted.
    frame_stats u_stats (
        .clk          (clk),
        .resetb       (resetb),
        .dvo          (dvo),
        .dtypeo       (dtypeo),
        .defect       (defect),
        .defect_count (defect_count),
        .row_count    (row_count),
        .stats_valid  (stats_valid)
    );

endmodule

// ==== verif/pixel_pipe_tb.sv ====
`timescale 1ns/10ps

module pixel_pipe_tb;

    import pix_pkg::*;

    localparam int data_width  = 16;
    localparam int frame_count = 8;
    localparam int wait_limit  = 400; // cycles allowed for any single wait.

    logic                         clk = 1'b0;
    logic                         resetb;
    logic                         dvi;
    logic [data_width-1:0]        datai;
    dtype_t                       dtypei;
    logic                         en;
    logic signed [data_width-1:0] threshold_upper;
    logic signed [data_width-1:0] threshold_lower;
    logic                         dvo;
    logic [data_width-1:0]        datao;
    dtype_t                       dtypeo;
    logic                         defect;
    logic [count_width-1:0]       defect_count;
    logic [count_width-1:0]       row_count;
    logic                         stats_valid;
    logic                         frame_error;

    // expected output stream is filled ahead of the stimulus.
    dtype_t                exp_type[$];
    logic [data_width-1:0] exp_data[$];
    logic                  exp_defect[$];
    logic [data_width-1:0] row_in[$];
    logic [data_width-1:0] row_out[$];
    logic                  row_def[$];

    int error_count;
    int check_count;
    int test_count;
    bit timed_out;

    pixel_pipe_top #(.DATA_WIDTH(data_width)) DUT (
        .clk             (clk),
        .resetb          (resetb),
        .dvi             (dvi),
        .datai           (datai),
        .dtypei          (dtypei),
        .en              (en),
        .threshold_upper (threshold_upper),
        .threshold_lower (threshold_lower),
        .dvo             (dvo),
        .datao           (datao),
        .dtypeo          (dtypeo),
        .defect          (defect),
        .defect_count    (defect_count),
        .row_count       (row_count),
        .stats_valid     (stats_valid),
        .frame_error     (frame_error)
    );

    always #4 clk = ~clk;

    task automatic compare_token(input dtype_t exp_t, input logic [data_width-1:0] exp_d,
                                 input dtype_t got_t, input logic [data_width-1:0] got_d);
        check_count++;
        if (got_t !== exp_t) begin
            $display("FAIL %0t dtypeo expected %s got %s", $time, exp_t.name(), got_t.name());
            error_count++;
        end else if (got_d !== exp_d) begin
            $display("FAIL %0t datao expected %h got %h", $time, exp_d, got_d);
            error_count++;
        end
    endtask

    task automatic compare_count(input string sig, input logic [count_width-1:0] exp_v,
                                 input logic [count_width-1:0] got_v);
        check_count++;
        if (got_v !== exp_v) begin
            $display("FAIL %0t %s expected %0d got %0d", $time, sig, exp_v, got_v);
            error_count++;
        end
    endtask

    task automatic compare_flag(input string sig, input logic exp_v, input logic got_v);
        check_count++;
        if (got_v !== exp_v) begin
            $display("FAIL %0t %s expected %b got %b", $time, sig, exp_v, got_v);
            error_count++;
        end
    endtask

    // output checker sampled away from the rising edge.
    always @(negedge clk) begin
        if (resetb && dvo) begin
            if (exp_type.size() == 0) begin
                $display("output token at %0t arrived with nothing left to match", $time);
                error_count++;
            end else begin
                compare_token(exp_type.pop_front(), exp_data.pop_front(), dtypeo, datao);
                compare_flag("defect", exp_defect.pop_front(), defect);
            end
        end else if (resetb && defect) begin
            $display("defect pulsed at %0t with no output token", $time);
            error_count++;
        end
    end

    task automatic expect_token(input dtype_t t, input logic [data_width-1:0] d,
                                input logic def);
        exp_type.push_back(t);
        exp_data.push_back(d);
        exp_defect.push_back(def);
    endtask

    task automatic send_token(input dtype_t t, input logic [data_width-1:0] d);
        dvi    = 1'b1;
        dtypei = t;
        datai  = d;
        @(negedge clk);
        dvi = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // three-pixel rule with the left neighbour taken from the modelled output.
    task automatic model_row(input logic en_m, inout int n_def);
        logic [data_width-1:0]        left;
        logic [data_width-1:0]        mid;
        logic [data_width-1:0]        right;
        logic signed [data_width-1:0] d1;
        logic signed [data_width-1:0] d2;
        logic signed [data_width-1:0] neg_lower;
        int                           avg;
        row_out.delete();
        row_def.delete();
        neg_lower = -threshold_lower;
        foreach (row_in[i]) begin
            if ((i == 0) || (i == row_in.size() - 1)) begin
                row_out.push_back(row_in[i]); // row edges are never checked.
                row_def.push_back(1'b0);
            end else begin
                left  = row_out[i-1];
                mid   = row_in[i];
                right = row_in[i+1];
                d1    = mid - right;
                d2    = mid - left;
                if (((d1 > threshold_upper) && (d2 > threshold_upper)) ||
                    ((d1 < neg_lower) && (d2 < neg_lower))) begin
                    n_def++;
                    avg = (int'(left) + int'(right)) / 2;
                    row_out.push_back(en_m ? avg[data_width-1:0] : mid);
                    row_def.push_back(1'b1);
                end else begin
                    row_out.push_back(mid);
                    row_def.push_back(1'b0);
                end
            end
        end
    endtask

    task automatic wait_for_stats();
        int waited;
        waited = 0;
        while (!stats_valid && (waited < wait_limit)) begin
            @(negedge clk);
            waited++;
        end
        if (!stats_valid) begin
            $display("stats_valid never pulsed after frame end at %0t", $time);
            error_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while ((exp_type.size() != 0) && (waited < wait_limit)) begin
            @(negedge clk);
            waited++;
        end
        if (exp_type.size() != 0) begin
            $display("%0d expected output tokens never appeared", exp_type.size());
            error_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_frame(input int t);
        int                    n_rows;
        int                    n_hdr;
        int                    n_pix;
        int                    base;
        int                    v;
        int                    n_def;
        int                    errs_before;
        logic [data_width-1:0] d;
        errs_before     = error_count;
        n_def           = 0;
        n_rows          = 1 + int'($urandom % 4);
        threshold_upper = data_width'(50 + $urandom % 251);
        threshold_lower = data_width'(50 + $urandom % 251);
        en              = (t < 2) ? t[0] : ($urandom % 2 == 1);
        d = data_width'($urandom);
        expect_token(dtype_frame_start, d, 1'b0);
        send_token(dtype_frame_start, d);
        for (int r = 0; r < n_rows; r++) begin
            n_hdr = int'($urandom % 3);
            for (int h = 0; h < n_hdr; h++) begin
                d = data_width'($urandom);
                expect_token(dtype_header, d, 1'b0);
                send_token(dtype_header, d);
            end
            n_pix = 3 + int'($urandom % 10);
            base  = 1500 + int'($urandom % 2000);
            row_in.delete();
            for (int i = 0; i < n_pix; i++) begin
                v = base + int'($urandom % 40);
                if ((i > 0) && (i < n_pix - 1) && ($urandom % 4 == 0)) begin
                    if ($urandom % 2 == 1) v = v + 400 + int'($urandom % 1000); // hot.
                    else v = v - 400 - int'($urandom % 1000);                   // cold.
                end
                row_in.push_back(data_width'(v));
            end
            model_row(en, n_def);
            d = data_width'($urandom);
            expect_token(dtype_row_start, d, 1'b0);
            foreach (row_out[i]) expect_token(dtype_pixel, row_out[i], row_def[i]);
            send_token(dtype_row_start, d);
            foreach (row_in[i]) begin
                send_token(dtype_pixel, row_in[i]);
                if ($urandom % 4 == 0) idle_cycles(1);
            end
            d = data_width'($urandom);
            expect_token(dtype_row_end, d, 1'b0);
            send_token(dtype_row_end, d);
            idle_cycles(1 + int'($urandom % 2)); // row end needs a free output slot.
        end
        d = data_width'($urandom);
        expect_token(dtype_frame_end, d, 1'b0);
        send_token(dtype_frame_end, d);
        wait_for_stats();
        if (!timed_out) begin
            compare_count("defect_count", count_width'(n_def), defect_count);
            compare_count("row_count", count_width'(n_rows), row_count);
            wait_for_drain();
            compare_flag("frame_error", 1'b0, frame_error);
        end
        test_count++;
        $display("test %0d: %0d rows, en %0b, %0d defects, %s", t, n_rows, en, n_def,
                 (error_count == errs_before) ? "ok" : "mismatch");
    endtask

    task automatic inject_stray_pixel();
        int                    waited;
        int                    errs_before;
        logic [data_width-1:0] d;
        errs_before = error_count;
        compare_flag("frame_error", 1'b0, frame_error);
        d = data_width'($urandom);
        expect_token(dtype_pixel, d, 1'b0); // outside a row it passes straight through.
        send_token(dtype_pixel, d);
        waited = 0;
        while (!frame_error && (waited < wait_limit)) begin
            @(negedge clk);
            waited++;
        end
        if (!frame_error) begin
            $display("frame_error did not rise after a pixel outside any row");
            error_count++;
            timed_out = 1'b1;
        end else begin
            wait_for_drain();
        end
        test_count++;
        $display("test %0d: stray pixel, %s", test_count - 1,
                 (error_count == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        resetb          = 1'b0;
        dvi             = 1'b0;
        datai           = '0;
        dtypei          = dtype_header;
        en              = 1'b0;
        threshold_upper = '0;
        threshold_lower = '0;
        error_count     = 0;
        check_count     = 0;
        test_count      = 0;
        timed_out       = 1'b0;
        void'($urandom(32'hbf8a));
        repeat (5) @(negedge clk);
        resetb = 1'b1;
        idle_cycles(2);
        for (int t = 0; (t < frame_count) && !timed_out; t++) begin
            run_frame(t);
        end
        if (!timed_out) inject_stray_pixel();
        idle_cycles(4);
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hdl/pix_pkg.sv
hdl/stream_decode.sv
hdl/defect_filter.sv
hdl/frame_stats.sv
hdl/pixel_pipe_top.sv
verif/pixel_pipe_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the pixel pipe testbench with verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module pixel_pipe_tb \
    -f all.f -o pixel_pipe_sim > build.log 2>&1 \
    && ./obj_dir/pixel_pipe_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } \
    || { grep -q "NO ERRORS" sim.log && echo "simulation passed" && exit 0; } \
    || { echo "simulation ended without a result"; exit 1; }
